// ==== src/sd_loader_pkg.sv ====
`default_nettype none

package sd_loader_pkg;

    localparam int SEC_ADDR_W = 32;
    localparam int FILE_NUM   = 3;
    localparam int FILE_SEL_W = 2;
    localparam int SEC_BYTES  = 512;
    localparam int RD_DATA_W  = 16;       // sd controller read word

    // one file on the card
    typedef struct packed {
        logic [SEC_ADDR_W-1:0] start_sec;
        logic [SEC_ADDR_W-1:0] sec_cnt;
        logic [31:0]           ddr_base;
    } file_entry_t;

    // loaded in table order
    localparam file_entry_t FILE_TABLE [0:FILE_NUM-1] = '{
        '{
            start_sec: 32'd100,
            sec_cnt:   32'd2,
            ddr_base:  32'h4000_0000
        },
        '{
            start_sec: 32'd200,
            sec_cnt:   32'd1,
            ddr_base:  32'h5000_0000
        },
        '{
            start_sec: 32'd300,
            sec_cnt:   32'd3,
            ddr_base:  32'h6000_0000
        }
    };

endpackage

`default_nettype wire

// ==== src/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    localparam int DMA_ADDR_W  = 32;
    localparam int DMA_DATA_W  = 64;

    // one sector per burst
    localparam int BURST_WORDS = 64;
    localparam int BURST_IDX_W = 6;

endpackage

`default_nettype wire

// ==== src/sector_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface sector_if;

    logic [dma_pkg::DMA_ADDR_W-1:0] ddr_addr;     // target of the sector in flight
    logic                           last_sector;  // final sector of the table
    logic                           filled;       // 64th word written
    logic                           draining;     // burst not finished yet

    // sequencer side
    modport seq (
        output ddr_addr,
        output last_sector,
        input  filled,
        input  draining
    );

    // buffer side
    modport buff (
        input  ddr_addr,
        input  last_sector,
        output filled,
        output draining
    );

endinterface

`default_nettype wire

// ==== src/file_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module file_sequencer (
    input  wire                                clk_50M,
    input  wire                                i_rst_n,
    input  wire                                i_sd_init_done,
    input  wire                                i_rd_busy,
    sector_if.seq                              sif,
    output logic                               o_rd_start_en,
    output logic [sd_loader_pkg::SEC_ADDR_W-1:0] o_rd_sec_addr,
    output logic                               o_load_done
);

    sd_loader_pkg::file_entry_t              cur_file;
    logic [sd_loader_pkg::FILE_SEL_W-1:0]    file_sel;
    logic [sd_loader_pkg::SEC_ADDR_W-1:0]    sec_offset;
    logic [dma_pkg::DMA_ADDR_W-1:0]          ddr_addr;
    logic                                    rd_pending;   // waiting for the sector to fill
    logic                                    last_filled;  // final sector is in the buffer
    logic                                    last_in_file;
    logic                                    start_ok;

    assign cur_file      = sd_loader_pkg::FILE_TABLE[file_sel];
    assign o_rd_sec_addr = cur_file.start_sec + sec_offset;
    assign last_in_file  = (sec_offset == cur_file.sec_cnt - 1'b1);

    assign sif.ddr_addr    = ddr_addr;
    assign sif.last_sector = last_in_file &&
                             (file_sel == sd_loader_pkg::FILE_SEL_W'(sd_loader_pkg::FILE_NUM - 1));

    // one sector at a time, never while the buffer drains
    assign start_ok = !i_rd_busy && !rd_pending && !sif.draining && !last_filled;

    always_ff @(posedge clk_50M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_start_en <= 1'b0;
            rd_pending    <= 1'b0;
            last_filled   <= 1'b0;
            o_load_done   <= 1'b0;
            file_sel      <= '0;
            sec_offset    <= '0;
        end else begin
            o_rd_start_en <= 1'b0;
            if (i_sd_init_done) begin
                if (start_ok) begin
                    o_rd_start_en <= 1'b1;
                    rd_pending    <= 1'b1;
                end

                if (sif.filled) begin
                    rd_pending <= 1'b0;
                    if (sif.last_sector) begin
                        last_filled <= 1'b1;
                    end
                    if (last_in_file) begin
                        sec_offset <= '0;
                        if (!sif.last_sector) begin
                            file_sel <= file_sel + 1'b1;
                        end
                    end else begin
                        sec_offset <= sec_offset + 1'b1;
                    end
                end

                // burst of the final sector has gone out
                if (last_filled && !sif.draining) begin
                    o_load_done <= 1'b1;
                end
            end
        end
    end

    // base on the first sector of a file, then step per sector
    always_ff @(posedge clk_50M) begin
        if (i_sd_init_done) begin
            if (start_ok && sec_offset == '0) begin
                ddr_addr <= cur_file.ddr_base;
            end else if (sif.filled) begin
                ddr_addr <= ddr_addr + dma_pkg::DMA_ADDR_W'(sd_loader_pkg::SEC_BYTES);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/halfword_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module halfword_packer (
    input  wire                                 clk_50M,
    input  wire                                 i_rst_n,
    input  wire                                 i_sd_init_done,
    input  wire                                 i_rd_val_en,
    input  wire  [sd_loader_pkg::RD_DATA_W-1:0] i_rd_val_data,
    output logic                                o_word_valid,
    output logic [dma_pkg::DMA_DATA_W-1:0]      o_word
);

    logic [1:0]                          hw_cnt;     // halfwords in the current word
    logic [sd_loader_pkg::RD_DATA_W-1:0] hw_swapped;
    logic [dma_pkg::DMA_DATA_W-1:0]      shreg;

    // card delivers the high byte first
    assign hw_swapped = {i_rd_val_data[7:0], i_rd_val_data[15:8]};
    assign o_word     = shreg;

    always_ff @(posedge clk_50M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hw_cnt       <= '0;
            o_word_valid <= 1'b0;
        end else if (!i_sd_init_done) begin
            hw_cnt       <= '0;
            o_word_valid <= 1'b0;
        end else if (i_rd_val_en) begin
            hw_cnt       <= hw_cnt + 1'b1;
            o_word_valid <= (hw_cnt == 2'd3);
        end else begin
            o_word_valid <= 1'b0;
        end
    end

    // newest halfword on top, first one ends up in 15:0
    always_ff @(posedge clk_50M) begin
        if (i_rd_val_en) begin
            shreg <= {hw_swapped, shreg[dma_pkg::DMA_DATA_W-1:sd_loader_pkg::RD_DATA_W]};
        end
    end

endmodule

`default_nettype wire

// ==== src/sector_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sector_buffer (
    input  wire                             clk_50M,
    input  wire                             i_rst_n,
    input  wire                             i_word_valid,
    input  wire  [dma_pkg::DMA_DATA_W-1:0]  i_word,
    input  wire                             i_dma_wbusy,
    input  wire                             i_dma_wvalid,
    sector_if.buff                          sif,
    output logic [dma_pkg::DMA_ADDR_W-1:0]  o_dma_waddr,
    output logic                            o_dma_wareq,
    output logic [dma_pkg::DMA_DATA_W-1:0]  o_dma_wdata
);

    logic [dma_pkg::DMA_DATA_W-1:0]  mem [0:dma_pkg::BURST_WORDS-1];
    logic [dma_pkg::BURST_IDX_W-1:0] wr_idx;
    logic [dma_pkg::BURST_IDX_W-1:0] rd_idx;
    logic                            draining;
    logic                            req_sent;   // request already made for this burst
    logic                            take_word;
    logic                            last_take;

    localparam logic [dma_pkg::BURST_IDX_W-1:0] LAST_IDX =
        dma_pkg::BURST_IDX_W'(dma_pkg::BURST_WORDS - 1);

    assign sif.filled   = i_word_valid && (wr_idx == LAST_IDX);
    assign sif.draining = draining;

    assign take_word   = draining && i_dma_wvalid;
    assign last_take   = take_word && (rd_idx == LAST_IDX);
    assign o_dma_wdata = mem[rd_idx];    // combinational read

    always_ff @(posedge clk_50M) begin
        if (i_word_valid) begin
            mem[wr_idx] <= i_word;
        end
        if (sif.filled) begin
            o_dma_waddr <= sif.ddr_addr;
        end
    end

    // indices wrap at 64 on their own
    always_ff @(posedge clk_50M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
        end else begin
            if (i_word_valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (take_word) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            draining <= 1'b0;
        end else if (sif.filled) begin
            draining <= 1'b1;
        end else if (last_take) begin
            draining <= 1'b0;
        end
    end

    // request once per burst, drop when the dma goes busy
    always_ff @(posedge clk_50M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dma_wareq <= 1'b0;
            req_sent    <= 1'b0;
        end else begin
            if (o_dma_wareq && i_dma_wbusy) begin
                o_dma_wareq <= 1'b0;
            end else if (draining && !req_sent && !i_dma_wbusy) begin
                o_dma_wareq <= 1'b1;
                req_sent    <= 1'b1;
            end
            if (last_take) begin
                req_sent <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sd_dma_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module sd_dma_loader (
    input  wire                                 clk_50M,
    input  wire                                 i_rst_n,
    input  wire                                 i_sd_init_done,

    // sd controller read side
    input  wire                                 i_rd_busy,
    input  wire                                 i_rd_val_en,
    input  wire  [sd_loader_pkg::RD_DATA_W-1:0] i_rd_val_data,
    output wire                                 o_rd_start_en,
    output wire  [sd_loader_pkg::SEC_ADDR_W-1:0] o_rd_sec_addr,

    // dma write port
    input  wire                                 i_dma_wbusy,
    input  wire                                 i_dma_wvalid,
    output wire  [dma_pkg::DMA_ADDR_W-1:0]      o_dma_waddr,
    output wire                                 o_dma_wareq,
    output wire  [dma_pkg::DMA_DATA_W-1:0]      o_dma_wdata,

    output wire                                 o_load_done
);

    wire                            word_valid;
    wire [dma_pkg::DMA_DATA_W-1:0]  word;

    sector_if sif ();

    file_sequencer u_file_sequencer (
        .clk_50M        (clk_50M),
        .i_rst_n        (i_rst_n),
        .i_sd_init_done (i_sd_init_done),
        .i_rd_busy      (i_rd_busy),
        .sif            (sif.seq),
        .o_rd_start_en  (o_rd_start_en),
        .o_rd_sec_addr  (o_rd_sec_addr),
        .o_load_done    (o_load_done)
    );

    halfword_packer u_halfword_packer (
        .clk_50M        (clk_50M),
        .i_rst_n        (i_rst_n),
        .i_sd_init_done (i_sd_init_done),
        .i_rd_val_en    (i_rd_val_en),
        .i_rd_val_data  (i_rd_val_data),
        .o_word_valid   (word_valid),
        .o_word         (word)
    );

    sector_buffer u_sector_buffer (
        .clk_50M      (clk_50M),
        .i_rst_n      (i_rst_n),
        .i_word_valid (word_valid),
        .i_word       (word),
        .i_dma_wbusy  (i_dma_wbusy),
        .i_dma_wvalid (i_dma_wvalid),
        .sif          (sif.buff),
        .o_dma_waddr  (o_dma_waddr),
        .o_dma_wareq  (o_dma_wareq),
        .o_dma_wdata  (o_dma_wdata)
    );

endmodule

`default_nettype wire

// ==== test/tb_sd_dma_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sd_dma_loader;

    localparam int SECTORS     = 6;
    localparam int HW_PER_SEC  = 256;     // halfwords in one sector
    localparam int WAIT_LIMIT  = 2000;
    localparam int IDLE_CYCLES = 500;

    typedef struct packed {
        logic [31:0] sec;
        logic [31:0] ddr;
    } expect_t;

    // load order across the file table
    localparam expect_t EXPECT_TAB [0:SECTORS-1] = '{
        '{sec: 32'd100, ddr: 32'h4000_0000},
        '{sec: 32'd101, ddr: 32'h4000_0200},
        '{sec: 32'd200, ddr: 32'h5000_0000},
        '{sec: 32'd300, ddr: 32'h6000_0000},
        '{sec: 32'd301, ddr: 32'h6000_0200},
        '{sec: 32'd302, ddr: 32'h6000_0400}
    };

    logic                                 clk_50M;
    logic                                 i_rst_n;
    logic                                 i_sd_init_done;
    logic                                 i_rd_busy;
    logic                                 i_rd_val_en;
    logic [sd_loader_pkg::RD_DATA_W-1:0]  i_rd_val_data;
    logic                                 i_dma_wbusy;
    logic                                 i_dma_wvalid;
    wire                                  o_rd_start_en;
    wire  [sd_loader_pkg::SEC_ADDR_W-1:0] o_rd_sec_addr;
    wire  [dma_pkg::DMA_ADDR_W-1:0]       o_dma_waddr;
    wire                                  o_dma_wareq;
    wire  [dma_pkg::DMA_DATA_W-1:0]       o_dma_wdata;
    wire                                  o_load_done;

    logic [31:0] lfsr;
    logic [15:0] hw_log    [0:HW_PER_SEC-1];            // halfwords sent for this sector
    logic [63:0] burst_log [0:dma_pkg::BURST_WORDS-1];  // words taken from the burst

    sd_dma_loader sd_dma_loader_inst (
        .clk_50M        (clk_50M),
        .i_rst_n        (i_rst_n),
        .i_sd_init_done (i_sd_init_done),
        .i_rd_busy      (i_rd_busy),
        .i_rd_val_en    (i_rd_val_en),
        .i_rd_val_data  (i_rd_val_data),
        .o_rd_start_en  (o_rd_start_en),
        .o_rd_sec_addr  (o_rd_sec_addr),
        .i_dma_wbusy    (i_dma_wbusy),
        .i_dma_wvalid   (i_dma_wvalid),
        .o_dma_waddr    (o_dma_waddr),
        .o_dma_wareq    (o_dma_wareq),
        .o_dma_wdata    (o_dma_wdata),
        .o_load_done    (o_load_done)
    );

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] swap_bytes(input logic [15:0] h);
        return {h[7:0], h[15:8]};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s, got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // inputs change 2 ns after the edge, outputs are settled by then
    task automatic next_cycle();
        @(posedge clk_50M);
        #2;
    endtask

    task automatic step_quiet(input string phase);
        next_cycle();
        check_value(64'(o_rd_start_en), 64'd0, {"read start ", phase});
        check_value(64'(o_dma_wareq), 64'd0, {"dma request ", phase});
    endtask

    task automatic wait_read_start();
        int n;
        n = 0;
        while (o_rd_start_en !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                abort_run("timed out waiting for a sector read request");
            end
            check_value(64'(o_dma_wareq), 64'd0, "dma request with no sector loaded");
            next_cycle();
            n++;
        end
    endtask

    task automatic serve_sector();
        logic [15:0] gap;
        logic [15:0] hw;
        i_rd_busy = 1'b1;
        for (int i = 0; i < HW_PER_SEC; i++) begin
            take_bits(2, gap);
            repeat (gap) begin
                step_quiet("while reading");
                i_rd_val_en = 1'b0;
            end
            step_quiet("while reading");
            take_bits(16, hw);
            hw_log[i]     = hw;
            i_rd_val_data = hw;
            i_rd_val_en   = 1'b1;
        end
        step_quiet("while reading");
        i_rd_val_en = 1'b0;
        i_rd_busy   = 1'b0;
    endtask

    task automatic wait_dma_request();
        int n;
        n = 0;
        while (o_dma_wareq !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                abort_run("timed out waiting for the dma write request");
            end
            next_cycle();
            check_value(64'(o_rd_start_en), 64'd0, "read start before the burst");
            n++;
        end
    endtask

    task automatic serve_burst();
        logic [15:0] gap;
        i_dma_wbusy = 1'b1;
        for (int k = 0; k < dma_pkg::BURST_WORDS; k++) begin
            take_bits(2, gap);
            repeat (gap) begin
                step_quiet("during a burst");
                i_dma_wvalid = 1'b0;
            end
            step_quiet("during a burst");
            burst_log[k] = o_dma_wdata;
            i_dma_wvalid = 1'b1;
        end
        step_quiet("during a burst");
        i_dma_wvalid = 1'b0;
        i_dma_wbusy  = 1'b0;
    endtask

    // word k holds halfwords 4k..4k+3, first one lowest
    task automatic check_burst_data(input int s);
        logic [63:0] exp;
        for (int k = 0; k < dma_pkg::BURST_WORDS; k++) begin
            exp = {swap_bytes(hw_log[4*k+3]), swap_bytes(hw_log[4*k+2]),
                   swap_bytes(hw_log[4*k+1]), swap_bytes(hw_log[4*k])};
            check_value(burst_log[k], exp, $sformatf("sector %0d burst word %0d", s, k));
        end
    endtask

    task automatic wait_load_done();
        int n;
        n = 0;
        while (o_load_done !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                abort_run("timed out waiting for the load to finish");
            end
            step_quiet("after the last burst");
            n++;
        end
    endtask

    initial begin
        lfsr           = 32'hf209;
        i_rst_n        = 1'b0;
        i_sd_init_done = 1'b0;
        i_rd_busy      = 1'b0;
        i_rd_val_en    = 1'b0;
        i_rd_val_data  = '0;
        i_dma_wbusy    = 1'b0;
        i_dma_wvalid   = 1'b0;

        repeat (16) begin
            step_quiet("in reset");
            check_value(64'(o_load_done), 64'd0, "load done in reset");
        end
        i_rst_n = 1'b1;

        // card not ready yet, nothing may move
        repeat (8) begin
            step_quiet("before init done");
            check_value(64'(o_load_done), 64'd0, "load done before init done");
        end
        i_sd_init_done = 1'b1;

        for (int s = 0; s < SECTORS; s++) begin
            wait_read_start();
            check_value(64'(o_rd_sec_addr), 64'(EXPECT_TAB[s].sec),
                        $sformatf("sector address of read %0d", s));
            serve_sector();
            wait_dma_request();
            check_value(64'(o_dma_waddr), 64'(EXPECT_TAB[s].ddr),
                        $sformatf("ddr address of burst %0d", s));
            check_value(64'(o_load_done), 64'd0, "load done too early");
            serve_burst();
            check_burst_data(s);
        end

        wait_load_done();
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            step_quiet("after load done");
            check_value(64'(o_load_done), 64'd1, "load done dropped");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sd_dma_loader.f ====
src/sd_loader_pkg.sv
src/dma_pkg.sv
src/sector_if.sv
src/file_sequencer.sv
src/halfword_packer.sv
src/sector_buffer.sv
src/sd_dma_loader.sv
test/tb_sd_dma_loader.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_sd_dma_loader
FILELIST  := sd_dma_loader.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/10ps
PASS_MSG  := Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
